/* hw/srio_req_pkg.sv */
// --------------------------------------------------
// field codes, limits and types for the requester
// one target endpoint, two alternating address slots
// transfer sizes are whole 8-byte beats, 4096 bytes max
// --------------------------------------------------
`default_nettype none

package srio_req_pkg;

	// packet type codes
	localparam logic [3:0] FTYPE_DOORBELL = 4'hA;
	localparam logic [3:0] FTYPE_NWRITE   = 4'h5;
	localparam logic [3:0] TTYPE_NWRITE   = 4'h4;
	localparam logic [1:0] PRIO_REQ       = 2'd1;

	// doorbell info payloads
	localparam logic [15:0] INFO_SELF_CHECK = 16'h0101;
	localparam logic [15:0] INFO_READY      = 16'h0100;
	localparam logic [15:0] INFO_BUSY       = 16'h01FF;
	// slot 0 answers 0x0201, slot 1 answers 0x0200
	localparam logic [15:0] INFO_INTEG_BASE = 16'h0200;

	// target endpoint
	localparam logic [15:0] TARGET_RESP_ID   = 16'h00F0;
	localparam logic [33:0] TARGET_ADDR_STEP = 34'h0_0010_0000;
	localparam int          TIMEOUT_CYCLES   = 1024;
	localparam int          TIMER_W          = $clog2(TIMEOUT_CYCLES);

	// packet geometry
	localparam int BEAT_BYTES    = 8;
	localparam int PKT_MAX_BEATS = 32;
	localparam int PKT_BYTES     = 256;
	localparam int FIFO_DEPTH    = 512;
	localparam int FIFO_AW       = $clog2(FIFO_DEPTH);

	typedef logic [15:0] dev_id_t;
	typedef logic [33:0] addr_t;
	typedef logic [63:0] beat_t;
	// bytes minus one
	typedef logic [11:0] xfer_size_t;

	// beat counter per packet, must hold PKT_MAX_BEATS itself
	localparam int BEAT_CNT_W  = $clog2(PKT_MAX_BEATS) + 1;
	// beat counter per transfer, up to 512 beats
	localparam int XFER_BEAT_W = $bits(xfer_size_t) - $clog2(BEAT_BYTES) + 1;

	typedef enum logic {
		DOORBELL,
		NWRITE
	} frame_kind_e;

	typedef enum logic [1:0] {
		ERR_NONE          = 2'b00,
		ERR_DB_TIMEOUT    = 2'b01,
		ERR_INTEG_TIMEOUT = 2'b10
	} err_type_e;

endpackage

`default_nettype wire

/* hw/srio_req_if.sv */
// --------------------------------------------------
// internal links of the requester
// beat stream: transfer on valid and ready, valid
// never waits for ready
// frame command: taken on valid and ready, done pulses
// on the last accepted ireq beat of the command
// --------------------------------------------------
`default_nettype none

interface beat_stream_if
	import srio_req_pkg::*;
();
	logic  valid;
	logic  ready;
	beat_t data;
	// user end-of-transfer flag
	logic  last;

	modport source (output valid, output data, output last, input ready);
	modport sink (input valid, input data, input last, output ready);
endinterface

interface frame_cmd_if
	import srio_req_pkg::*;
();
	logic        valid;
	logic        ready;
	frame_kind_e kind;
	// doorbell payload, unused for nwrite
	logic [15:0] info;
	// nwrite base address of the slot
	addr_t       addr;
	xfer_size_t  size;
	logic        done;

	modport master (
		output valid, output kind, output info, output addr, output size,
		input ready, input done
	);
	modport slave (
		input valid, input kind, input info, input addr, input size,
		output ready, output done
	);
endinterface

`default_nettype wire

/* hw/user_data_fifo.sv */
// --------------------------------------------------
// user beat buffer, FIFO_DEPTH deep, fall-through read
// writes while full are refused through wr_ready_o
// --------------------------------------------------
`default_nettype none

module user_data_fifo
	import srio_req_pkg::*;
(
	input  logic  log_clk,
	input  logic  log_rst,
	input  logic  wr_valid_i,
	input  beat_t wr_data_i,
	input  logic  wr_last_i,
	output logic  wr_ready_o,
	beat_stream_if.source rd
);
	beat_t mem_data [FIFO_DEPTH];
	logic  mem_last [FIFO_DEPTH];

	// one extra bit tells full from empty
	logic [FIFO_AW:0] wr_ptr_q;
	logic [FIFO_AW:0] rd_ptr_q;
	logic             empty;
	logic             full;
	logic             push;
	logic             pop;

	assign empty = (wr_ptr_q == rd_ptr_q);
	assign full  = (wr_ptr_q[FIFO_AW] != rd_ptr_q[FIFO_AW]) &&
		(wr_ptr_q[FIFO_AW-1:0] == rd_ptr_q[FIFO_AW-1:0]);

	assign wr_ready_o = !full;
	assign push       = wr_valid_i && !full;
	assign pop        = rd.valid && rd.ready;

	// head word is always on the read side
	assign rd.valid = !empty;
	assign rd.data  = mem_data[rd_ptr_q[FIFO_AW-1:0]];
	assign rd.last  = mem_last[rd_ptr_q[FIFO_AW-1:0]];

	always_ff @(posedge log_clk) begin
		if (push) begin
			mem_data[wr_ptr_q[FIFO_AW-1:0]] <= wr_data_i;
			mem_last[wr_ptr_q[FIFO_AW-1:0]] <= wr_last_i;
		end
	end

	always_ff @(posedge log_clk or posedge log_rst) begin
		if (log_rst) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/req_sequencer.sv */
// --------------------------------------------------
// requester control: self-check, nwrite, integrity
// doorbell and the response waits
// self-check wins over nwrite when both are requested
// status flags keep their value until the next check
// --------------------------------------------------
`default_nettype none

module req_sequencer
	import srio_req_pkg::*;
(
	input  logic        log_clk,
	input  logic        log_rst,
	input  logic        self_check_i,
	input  logic        nwr_req_i,
	input  xfer_size_t  nwr_size_i,
	input  logic        link_initialized_i,
	input  logic        iresp_tvalid_i,
	input  beat_t       iresp_tdata_i,
	input  logic [31:0] iresp_tuser_i,
	input  dev_id_t     des_id_i,
	output logic        rapidio_ready_o,
	output logic        nwr_ready_o,
	output logic        nwr_busy_o,
	output logic        nwr_ack_done_o,
	output logic        error_o,
	output err_type_e   error_type_o,
	output dev_id_t     error_target_id_o,
	frame_cmd_if.master cmd
);
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SELF_CHECK,
		ST_WAIT_CHECK_RESP,
		ST_NWRITE,
		ST_INTEG_DB,
		ST_WAIT_INTEG_ACK
	} seq_state_e;

	seq_state_e         state_q;
	logic               slot_q;
	logic [TIMER_W-1:0] timer_q;
	logic               waiting;
	logic               timeout;
	logic               resp_hit;
	logic [15:0]        resp_info;
	logic [15:0]        integ_code;

	// doorbell from the target endpoint
	assign resp_hit = iresp_tvalid_i &&
		(iresp_tdata_i[55:52] == FTYPE_DOORBELL) &&
		(iresp_tuser_i[31:16] == TARGET_RESP_ID);
	assign resp_info = iresp_tdata_i[31:16];

	// 0x0201 in slot 0, 0x0200 in slot 1
	assign integ_code = INFO_INTEG_BASE | {15'd0, ~slot_q};

	assign rapidio_ready_o = (state_q == ST_IDLE);

	// timer starts from zero on the first wait cycle
	assign waiting = (state_q == ST_WAIT_CHECK_RESP) || (state_q == ST_WAIT_INTEG_ACK);
	assign timeout = waiting && (timer_q == TIMER_W'(TIMEOUT_CYCLES - 1));

	always_ff @(posedge log_clk or posedge log_rst) begin
		if (log_rst)
			timer_q <= '0;
		else if (waiting)
			timer_q <= timer_q + 1'b1;
		else
			timer_q <= '0;
	end

	always_ff @(posedge log_clk or posedge log_rst) begin
		if (log_rst) begin
			state_q           <= ST_IDLE;
			slot_q            <= 1'b0;
			nwr_ready_o       <= 1'b0;
			nwr_busy_o        <= 1'b0;
			nwr_ack_done_o    <= 1'b0;
			error_o           <= 1'b0;
			error_type_o      <= ERR_NONE;
			error_target_id_o <= '0;
			cmd.valid         <= 1'b0;
			cmd.kind          <= DOORBELL;
			cmd.info          <= '0;
			cmd.addr          <= '0;
			cmd.size          <= '0;
		end else begin
			nwr_ack_done_o <= 1'b0;
			error_o        <= 1'b0;
			if (cmd.valid && cmd.ready)
				cmd.valid <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (link_initialized_i && self_check_i) begin
						nwr_ready_o <= 1'b0;
						nwr_busy_o  <= 1'b0;
						cmd.valid   <= 1'b1;
						cmd.kind    <= DOORBELL;
						cmd.info    <= INFO_SELF_CHECK;
						state_q     <= ST_SELF_CHECK;
					end else if (link_initialized_i && nwr_req_i) begin
						cmd.valid <= 1'b1;
						cmd.kind  <= NWRITE;
						cmd.info  <= '0;
						cmd.addr  <= slot_q ? TARGET_ADDR_STEP : '0;
						cmd.size  <= nwr_size_i;
						state_q   <= ST_NWRITE;
					end
				end
				ST_SELF_CHECK: begin
					if (cmd.done)
						state_q <= ST_WAIT_CHECK_RESP;
				end
				ST_WAIT_CHECK_RESP: begin
					// other infos from the target are ignored here
					if (resp_hit && resp_info == INFO_READY) begin
						nwr_ready_o <= 1'b1;
						nwr_busy_o  <= 1'b0;
						state_q     <= ST_IDLE;
					end else if (resp_hit && resp_info == INFO_BUSY) begin
						nwr_ready_o <= 1'b0;
						nwr_busy_o  <= 1'b1;
						state_q     <= ST_IDLE;
					end else if (timeout) begin
						error_o           <= 1'b1;
						error_type_o      <= ERR_DB_TIMEOUT;
						error_target_id_o <= des_id_i;
						state_q           <= ST_IDLE;
					end
				end
				ST_NWRITE: begin
					// data is out, ask the target to confirm it
					if (cmd.done) begin
						cmd.valid <= 1'b1;
						cmd.kind  <= DOORBELL;
						cmd.info  <= integ_code;
						state_q   <= ST_INTEG_DB;
					end
				end
				ST_INTEG_DB: begin
					if (cmd.done)
						state_q <= ST_WAIT_INTEG_ACK;
				end
				ST_WAIT_INTEG_ACK: begin
					if (resp_hit && resp_info == integ_code) begin
						nwr_ack_done_o <= 1'b1;
						// next transfer goes to the other slot
						slot_q         <= ~slot_q;
						state_q        <= ST_IDLE;
					end else if (timeout) begin
						error_o           <= 1'b1;
						error_type_o      <= ERR_INTEG_TIMEOUT;
						error_target_id_o <= des_id_i;
						state_q           <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/req_framer.sv */
// --------------------------------------------------
// ireq packet builder for doorbell and nwrite commands
// nwrite packets are PKT_MAX_BEATS beats at most
// a user last beat ends the transfer early, the
// header size already sent is not corrected
// --------------------------------------------------
`default_nettype none

module req_framer
	import srio_req_pkg::*;
(
	input  logic        log_clk,
	input  logic        log_rst,
	input  dev_id_t     src_id_i,
	input  dev_id_t     des_id_i,
	input  logic        ireq_tready_i,
	output logic        ireq_tvalid_o,
	output logic        ireq_tlast_o,
	output beat_t       ireq_tdata_o,
	output logic [7:0]  ireq_tkeep_o,
	output logic [31:0] ireq_tuser_o,
	frame_cmd_if.slave  cmd,
	beat_stream_if.sink data
);
	typedef enum logic [1:0] {
		F_IDLE,
		F_DB,
		F_DATA
	} frame_state_e;

	frame_state_e           state_q;
	logic [BEAT_CNT_W-1:0]  pkt_beats_q;
	logic [BEAT_CNT_W-1:0]  fetch_cnt_q;
	// beats left after the current packet
	logic [XFER_BEAT_W-1:0] rem_beats_q;
	addr_t                  addr_q;
	logic [7:0]             tid_q;
	logic [XFER_BEAT_W-1:0] cmd_beats;
	logic [BEAT_CNT_W-1:0]  cmd_pkt;
	logic [BEAT_CNT_W-1:0]  next_pkt;
	addr_t                  next_addr;
	logic [7:0]             cmd_tid;
	logic                   out_free;
	logic                   pkt_fetched;
	logic                   pkt_end;

	function automatic logic [BEAT_CNT_W-1:0] pkt_len(input logic [XFER_BEAT_W-1:0] beats);
		if (beats > XFER_BEAT_W'(PKT_MAX_BEATS))
			return BEAT_CNT_W'(PKT_MAX_BEATS);
		return BEAT_CNT_W'(beats);
	endfunction

	function automatic beat_t nwr_header(input logic [7:0] tid,
		input logic [BEAT_CNT_W-1:0] beats, input addr_t addr);
		logic [7:0] size;
		size = 8'(beats * BEAT_BYTES - 1);
		return {tid, FTYPE_NWRITE, TTYPE_NWRITE, 1'b0, PRIO_REQ, 1'b0, size, 2'b00, addr};
	endfunction

	// info rides in address bits 31:16
	function automatic beat_t db_header(input logic [15:0] info);
		return {8'h00, FTYPE_DOORBELL, 4'h0, 1'b0, PRIO_REQ, 1'b0, 8'h00, 4'h0, info, 16'h0000};
	endfunction

	assign cmd_beats = XFER_BEAT_W'(cmd.size >> $clog2(BEAT_BYTES)) + XFER_BEAT_W'(1);
	assign cmd_pkt   = pkt_len(cmd_beats);
	// transaction id is the slot, recovered from the base
	assign cmd_tid   = 8'(cmd.addr / TARGET_ADDR_STEP);
	assign next_pkt  = pkt_len(rem_beats_q);
	assign next_addr = addr_q + addr_t'(PKT_BYTES);

	// output register may load this cycle
	assign out_free    = !ireq_tvalid_o || ireq_tready_i;
	assign pkt_fetched = (fetch_cnt_q == pkt_beats_q);
	assign pkt_end     = (BEAT_CNT_W'(fetch_cnt_q + 1'b1) == pkt_beats_q) || data.last;

	assign cmd.ready  = (state_q == F_IDLE);
	assign cmd.done   = ireq_tvalid_o && ireq_tready_i && ireq_tlast_o &&
		((state_q == F_DB) || (rem_beats_q == '0));
	assign data.ready = (state_q == F_DATA) && out_free && !pkt_fetched;

	assign ireq_tkeep_o = 8'hFF;
	assign ireq_tuser_o = {src_id_i, des_id_i};

	always_ff @(posedge log_clk or posedge log_rst) begin
		if (log_rst) begin
			state_q       <= F_IDLE;
			ireq_tvalid_o <= 1'b0;
			ireq_tlast_o  <= 1'b0;
			pkt_beats_q   <= '0;
			fetch_cnt_q   <= '0;
			rem_beats_q   <= '0;
		end else begin
			case (state_q)
				F_IDLE: begin
					if (cmd.valid) begin
						ireq_tvalid_o <= 1'b1;
						if (cmd.kind == DOORBELL) begin
							ireq_tlast_o <= 1'b1;
							state_q      <= F_DB;
						end else begin
							ireq_tlast_o <= 1'b0;
							pkt_beats_q  <= cmd_pkt;
							fetch_cnt_q  <= '0;
							rem_beats_q  <= cmd_beats - XFER_BEAT_W'(cmd_pkt);
							state_q      <= F_DATA;
						end
					end
				end
				F_DB: begin
					if (ireq_tready_i) begin
						ireq_tvalid_o <= 1'b0;
						ireq_tlast_o  <= 1'b0;
						state_q       <= F_IDLE;
					end
				end
				F_DATA: begin
					if (out_free && !pkt_fetched) begin
						// pull the next data beat, bubble if the FIFO ran dry
						ireq_tvalid_o <= data.valid;
						if (data.valid) begin
							fetch_cnt_q  <= fetch_cnt_q + 1'b1;
							ireq_tlast_o <= pkt_end;
							if (data.last) begin
								pkt_beats_q <= fetch_cnt_q + 1'b1;
								rem_beats_q <= '0;
							end
						end
					end else if (out_free && rem_beats_q != '0) begin
						// next packet header
						ireq_tvalid_o <= 1'b1;
						ireq_tlast_o  <= 1'b0;
						pkt_beats_q   <= next_pkt;
						fetch_cnt_q   <= '0;
						rem_beats_q   <= rem_beats_q - XFER_BEAT_W'(next_pkt);
					end else if (out_free) begin
						ireq_tvalid_o <= 1'b0;
						ireq_tlast_o  <= 1'b0;
						state_q       <= F_IDLE;
					end
				end
				default: state_q <= F_IDLE;
			endcase
		end
	end

	// beat payload and packet address
	always_ff @(posedge log_clk) begin
		if (state_q == F_IDLE && cmd.valid) begin
			if (cmd.kind == DOORBELL) begin
				ireq_tdata_o <= db_header(cmd.info);
			end else begin
				ireq_tdata_o <= nwr_header(cmd_tid, cmd_pkt, cmd.addr);
				addr_q       <= cmd.addr;
				tid_q        <= cmd_tid;
			end
		end else if (state_q == F_DATA && out_free) begin
			if (!pkt_fetched && data.valid) begin
				ireq_tdata_o <= data.data;
			end else if (pkt_fetched && rem_beats_q != '0) begin
				ireq_tdata_o <= nwr_header(tid_q, next_pkt, next_addr);
				addr_q       <= next_addr;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/db_requester.sv */
// --------------------------------------------------
// RapidIO logical-layer requester, one target endpoint
// nwr_size_i is sampled with nwr_req_i
// iresp has no back-pressure, all beats are full
// --------------------------------------------------
`default_nettype none

module db_requester
	import srio_req_pkg::*;
(
	input  logic        log_clk,
	input  logic        log_rst,
	input  dev_id_t     src_id_i,
	input  dev_id_t     des_id_i,
	input  logic        self_check_i,
	input  logic        nwr_req_i,
	input  xfer_size_t  nwr_size_i,
	input  logic        link_initialized_i,
	input  logic        user_tvalid_i,
	input  beat_t       user_tdata_i,
	input  logic        user_tlast_i,
	input  logic        ireq_tready_i,
	input  logic        iresp_tvalid_i,
	input  beat_t       iresp_tdata_i,
	input  logic [31:0] iresp_tuser_i,
	output logic        user_tready_o,
	output logic        rapidio_ready_o,
	output logic        nwr_ready_o,
	output logic        nwr_busy_o,
	output logic        nwr_ack_done_o,
	output logic        error_o,
	output err_type_e   error_type_o,
	output dev_id_t     error_target_id_o,
	output logic        ireq_tvalid_o,
	output logic        ireq_tlast_o,
	output beat_t       ireq_tdata_o,
	output logic [7:0]  ireq_tkeep_o,
	output logic [31:0] ireq_tuser_o
);
	beat_stream_if beat_if ();
	frame_cmd_if   cmd_if ();

	// user beats wait here until the nwrite is framed
	user_data_fifo u_fifo (
		.log_clk    (log_clk),
		.log_rst    (log_rst),
		.wr_valid_i (user_tvalid_i),
		.wr_data_i  (user_tdata_i),
		.wr_last_i  (user_tlast_i),
		.wr_ready_o (user_tready_o),
		.rd         (beat_if.source)
	);

	req_sequencer u_seq (
		.log_clk            (log_clk),
		.log_rst            (log_rst),
		.self_check_i       (self_check_i),
		.nwr_req_i          (nwr_req_i),
		.nwr_size_i         (nwr_size_i),
		.link_initialized_i (link_initialized_i),
		.iresp_tvalid_i     (iresp_tvalid_i),
		.iresp_tdata_i      (iresp_tdata_i),
		.iresp_tuser_i      (iresp_tuser_i),
		.des_id_i           (des_id_i),
		.rapidio_ready_o    (rapidio_ready_o),
		.nwr_ready_o        (nwr_ready_o),
		.nwr_busy_o         (nwr_busy_o),
		.nwr_ack_done_o     (nwr_ack_done_o),
		.error_o            (error_o),
		.error_type_o       (error_type_o),
		.error_target_id_o  (error_target_id_o),
		.cmd                (cmd_if.master)
	);

	req_framer u_framer (
		.log_clk       (log_clk),
		.log_rst       (log_rst),
		.src_id_i      (src_id_i),
		.des_id_i      (des_id_i),
		.ireq_tready_i (ireq_tready_i),
		.ireq_tvalid_o (ireq_tvalid_o),
		.ireq_tlast_o  (ireq_tlast_o),
		.ireq_tdata_o  (ireq_tdata_o),
		.ireq_tkeep_o  (ireq_tkeep_o),
		.ireq_tuser_o  (ireq_tuser_o),
		.cmd           (cmd_if.slave),
		.data          (beat_if.sink)
	);

endmodule

`default_nettype wire

/* tb/db_requester_asserts.sv */
// --------------------------------------------------
// protocol assertions, bound into db_requester
// checked only while log_rst is low
// --------------------------------------------------
`default_nettype none

module db_requester_asserts
	import srio_req_pkg::*;
(
	input logic        log_clk,
	input logic        log_rst,
	input logic        ireq_tvalid_o,
	input logic        ireq_tready_i,
	input logic        ireq_tlast_o,
	input beat_t       ireq_tdata_o,
	input logic [31:0] ireq_tuser_o,
	input logic        error_o,
	input err_type_e   error_type_o,
	input logic        nwr_ack_done_o
);
	// failed assertion count
	int fails = 0;

	// a stalled ireq beat stays put
	property p_ireq_hold;
		@(posedge log_clk) disable iff (log_rst)
		ireq_tvalid_o && !ireq_tready_i |=>
			ireq_tvalid_o && $stable(ireq_tdata_o) && $stable(ireq_tlast_o) &&
			$stable(ireq_tuser_o);
	endproperty

	// error is one cycle wide
	property p_err_pulse;
		@(posedge log_clk) disable iff (log_rst)
		error_o |=> !error_o;
	endproperty

	// an error always names its cause
	property p_err_typed;
		@(posedge log_clk) disable iff (log_rst)
		error_o |-> error_type_o != ERR_NONE;
	endproperty

	// success and failure exclude each other
	property p_ack_xor_err;
		@(posedge log_clk) disable iff (log_rst)
		!(nwr_ack_done_o && error_o);
	endproperty

	a_ireq_hold: assert property (p_ireq_hold)
		else begin
			fails++;
			$error("ireq beat changed while stalled");
		end
	a_err_pulse: assert property (p_err_pulse)
		else begin
			fails++;
			$error("error_o longer than one cycle");
		end
	a_err_typed: assert property (p_err_typed)
		else begin
			fails++;
			$error("error_o with type ERR_NONE");
		end
	a_ack_xor_err: assert property (p_ack_xor_err)
		else begin
			fails++;
			$error("nwr_ack_done_o and error_o high together");
		end

endmodule

`default_nettype wire

/* tb/db_requester_tb.sv */
// --------------------------------------------------
// directed testbench for db_requester
// target replies are injected on iresp by the tests
// ireq_tready_i toggles randomly the whole run
// timeout tests wait the full TIMEOUT_CYCLES
// --------------------------------------------------
`default_nettype none

module db_requester_tb
	import srio_req_pkg::*;
();
	localparam dev_id_t SRC_ID      = 16'h0012;
	localparam dev_id_t DES_ID      = 16'h00A5;
	localparam dev_id_t BAD_ID      = 16'h0033;
	// 3 self-check doorbells, 43 + 6 beats of nwrite traffic
	localparam int      TOTAL_BEATS = 52;
	localparam int      RUN_LIMIT   = TOTAL_BEATS * 4 + 4 * TIMEOUT_CYCLES + 1000;

	logic        log_clk;
	logic        log_rst;
	logic        self_check_i;
	logic        nwr_req_i;
	xfer_size_t  nwr_size_i;
	logic        link_initialized_i;
	logic        user_tvalid_i;
	beat_t       user_tdata_i;
	logic        user_tlast_i;
	logic        ireq_tready_i = 1'b0;
	logic        iresp_tvalid_i;
	beat_t       iresp_tdata_i;
	logic [31:0] iresp_tuser_i;
	logic        user_tready_o;
	logic        rapidio_ready_o;
	logic        nwr_ready_o;
	logic        nwr_busy_o;
	logic        nwr_ack_done_o;
	logic        error_o;
	err_type_e   error_type_o;
	dev_id_t     error_target_id_o;
	logic        ireq_tvalid_o;
	logic        ireq_tlast_o;
	beat_t       ireq_tdata_o;
	logic [7:0]  ireq_tkeep_o;
	logic [31:0] ireq_tuser_o;

	integer    seed = 32'h4bcd;
	int        cycles = 0;
	int        checks = 0;
	int        errors = 0;
	int        err_pulses = 0;
	int        ack_pulses = 0;
	err_type_e seen_err_type = ERR_NONE;
	dev_id_t   seen_err_id = '0;
	// accepted ireq beats
	beat_t     cap_data [$];
	logic      cap_last [$];
	// user beats still expected on ireq
	beat_t     sent [$];

	db_requester u_dut (
		.log_clk            (log_clk),
		.log_rst            (log_rst),
		.src_id_i           (SRC_ID),
		.des_id_i           (DES_ID),
		.self_check_i       (self_check_i),
		.nwr_req_i          (nwr_req_i),
		.nwr_size_i         (nwr_size_i),
		.link_initialized_i (link_initialized_i),
		.user_tvalid_i      (user_tvalid_i),
		.user_tdata_i       (user_tdata_i),
		.user_tlast_i       (user_tlast_i),
		.ireq_tready_i      (ireq_tready_i),
		.iresp_tvalid_i     (iresp_tvalid_i),
		.iresp_tdata_i      (iresp_tdata_i),
		.iresp_tuser_i      (iresp_tuser_i),
		.user_tready_o      (user_tready_o),
		.rapidio_ready_o    (rapidio_ready_o),
		.nwr_ready_o        (nwr_ready_o),
		.nwr_busy_o         (nwr_busy_o),
		.nwr_ack_done_o     (nwr_ack_done_o),
		.error_o            (error_o),
		.error_type_o       (error_type_o),
		.error_target_id_o  (error_target_id_o),
		.ireq_tvalid_o      (ireq_tvalid_o),
		.ireq_tlast_o       (ireq_tlast_o),
		.ireq_tdata_o       (ireq_tdata_o),
		.ireq_tkeep_o       (ireq_tkeep_o),
		.ireq_tuser_o       (ireq_tuser_o)
	);

	bind db_requester db_requester_asserts u_asserts (
		.log_clk        (log_clk),
		.log_rst        (log_rst),
		.ireq_tvalid_o  (ireq_tvalid_o),
		.ireq_tready_i  (ireq_tready_i),
		.ireq_tlast_o   (ireq_tlast_o),
		.ireq_tdata_o   (ireq_tdata_o),
		.ireq_tuser_o   (ireq_tuser_o),
		.error_o        (error_o),
		.error_type_o   (error_type_o),
		.nwr_ack_done_o (nwr_ack_done_o)
	);

	initial begin
		log_clk = 1'b0;
		forever #5 log_clk = ~log_clk;
	end

	// sink stalls about one cycle in four
	always @(posedge log_clk)
		ireq_tready_i <= ($random(seed) & 3) != 0;

	// capture accepted ireq beats and count status pulses
	always @(posedge log_clk) begin
		if (!log_rst && ireq_tvalid_o && ireq_tready_i) begin
			cap_data.push_back(ireq_tdata_o);
			cap_last.push_back(ireq_tlast_o);
			// sideband is the same on every beat
			check_id(ireq_tuser_o[31:16], SRC_ID, "ireq tuser source id");
			check_id(ireq_tuser_o[15:0], DES_ID, "ireq tuser destination id");
			check_keep(ireq_tkeep_o, 8'hFF, "ireq tkeep");
		end
		if (error_o) begin
			err_pulses++;
			seen_err_type = error_type_o;
			seen_err_id   = error_target_id_o;
		end
		if (nwr_ack_done_o)
			ack_pulses++;
	end

	// run watchdog
	always @(posedge log_clk) begin
		cycles++;
		if (cycles >= RUN_LIMIT) begin
			$display("timeout: no end of test after %0d cycles", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	// header beat from the field layout
	function automatic beat_t make_header(input logic [7:0] tid, input logic [3:0] ftype,
		input logic [3:0] ttype, input logic [7:0] size, input addr_t addr);
		beat_t h;
		h          = '0;
		h[63:56]   = tid;
		h[55:52]   = ftype;
		h[51:48]   = ttype;
		h[46:45]   = PRIO_REQ;
		h[43:36]   = size;
		h[33:0]    = addr;
		return h;
	endfunction

	function automatic beat_t db_beat(input logic [15:0] info);
		return make_header(8'h00, FTYPE_DOORBELL, 4'h0, 8'h00, {2'b00, info, 16'h0000});
	endfunction

	task automatic check_beat(input beat_t got, input beat_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s expected %h got %h", $time, what, exp, got);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s expected %b got %b", $time, what, exp, got);
		end
	endtask

	task automatic check_err(input err_type_e got, input err_type_e exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s expected %s got %s", $time, what, exp.name(), got.name());
		end
	endtask

	task automatic check_id(input dev_id_t got, input dev_id_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s expected %h got %h", $time, what, exp, got);
		end
	endtask

	task automatic check_keep(input logic [7:0] got, input logic [7:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s expected %h got %h", $time, what, exp, got);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		checks++;
		if (got != exp) begin
			errors++;
			$display("FAIL %0t: %s expected %0d got %0d", $time, what, exp, got);
		end
	endtask

	task automatic pulse_self_check();
		@(posedge log_clk);
		self_check_i <= 1'b1;
		@(posedge log_clk);
		self_check_i <= 1'b0;
	endtask

	task automatic pulse_nwr_req(input xfer_size_t size);
		@(posedge log_clk);
		nwr_req_i  <= 1'b1;
		nwr_size_i <= size;
		@(posedge log_clk);
		nwr_req_i  <= 1'b0;
	endtask

	// one doorbell reply from endpoint id on iresp
	task automatic send_resp(input logic [15:0] info, input dev_id_t id);
		@(posedge log_clk);
		iresp_tvalid_i <= 1'b1;
		iresp_tdata_i  <= db_beat(info);
		iresp_tuser_i  <= {id, SRC_ID};
		@(posedge log_clk);
		iresp_tvalid_i <= 1'b0;
	endtask

	// random user beats into the FIFO, last flag on the final one
	task automatic write_user(input int nbeats);
		beat_t d;
		@(posedge log_clk);
		for (int i = 0; i < nbeats; i++) begin
			d = {$random(seed), $random(seed)};
			sent.push_back(d);
			user_tvalid_i <= 1'b1;
			user_tdata_i  <= d;
			user_tlast_i  <= (i == nbeats - 1);
			@(posedge log_clk);
			while (!user_tready_o)
				@(posedge log_clk);
		end
		user_tvalid_i <= 1'b0;
		user_tlast_i  <= 1'b0;
	endtask

	// back in IDLE, plus one edge so the pulse counters settle
	task automatic wait_idle();
		@(posedge log_clk);
		while (!rapidio_ready_o)
			@(posedge log_clk);
		@(posedge log_clk);
	endtask

	task automatic expect_beat(input beat_t exp, input logic exp_last, input string what);
		beat_t got;
		logic  got_last;
		while (cap_data.size() == 0)
			@(posedge log_clk);
		got      = cap_data.pop_front();
		got_last = cap_last.pop_front();
		check_beat(got, exp, what);
		check_bit(got_last, exp_last, {what, " tlast"});
	endtask

	// header then the packet's user beats
	task automatic expect_packet(input logic [7:0] tid, input addr_t addr,
		input logic [7:0] size, input int nbeats);
		beat_t hdr;
		hdr = make_header(tid, FTYPE_NWRITE, TTYPE_NWRITE, size, addr);
		expect_beat(hdr, 1'b0, "nwrite header");
		for (int i = 0; i < nbeats; i++)
			expect_beat(sent.pop_front(), i == nbeats - 1, "nwrite data");
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before)
			$display("test %s: ok", name);
		else
			$display("test %s: failed with %0d errors", name, errors - errs_before);
	endtask

	task automatic test_self_check_ready();
		int e0;
		int err0;
		e0   = errors;
		err0 = err_pulses;
		check_bit(rapidio_ready_o, 1'b1, "rapidio_ready_o after reset");
		check_bit(user_tready_o, 1'b1, "user_tready_o with FIFO empty");
		pulse_self_check();
		expect_beat(db_beat(INFO_SELF_CHECK), 1'b1, "self-check doorbell");
		check_bit(rapidio_ready_o, 1'b0, "rapidio_ready_o while waiting");
		send_resp(INFO_READY, TARGET_RESP_ID);
		wait_idle();
		check_bit(nwr_ready_o, 1'b1, "nwr_ready_o on ready");
		check_bit(nwr_busy_o, 1'b0, "nwr_busy_o on ready");
		check_bit(rapidio_ready_o, 1'b1, "rapidio_ready_o back in idle");
		check_count(err_pulses - err0, 0, "error pulses");
		report_test("self_check_ready", e0);
	endtask

	task automatic test_self_check_busy();
		int e0;
		e0 = errors;
		pulse_self_check();
		expect_beat(db_beat(INFO_SELF_CHECK), 1'b1, "self-check doorbell");
		// reply from a foreign endpoint, must not end the wait
		send_resp(INFO_READY, BAD_ID);
		repeat (4) @(posedge log_clk);
		check_bit(rapidio_ready_o, 1'b0, "still waiting after foreign reply");
		check_bit(nwr_ready_o, 1'b0, "nwr_ready_o after foreign reply");
		send_resp(INFO_BUSY, TARGET_RESP_ID);
		wait_idle();
		check_bit(nwr_busy_o, 1'b1, "nwr_busy_o on busy");
		check_bit(nwr_ready_o, 1'b0, "nwr_ready_o on busy");
		report_test("self_check_busy", e0);
	endtask

	task automatic test_self_check_timeout();
		int e0;
		int err0;
		e0   = errors;
		err0 = err_pulses;
		pulse_self_check();
		expect_beat(db_beat(INFO_SELF_CHECK), 1'b1, "self-check doorbell");
		wait_idle();
		check_count(err_pulses - err0, 1, "doorbell timeout pulses");
		check_err(seen_err_type, ERR_DB_TIMEOUT, "error type");
		check_id(seen_err_id, DES_ID, "error target id");
		report_test("self_check_timeout", e0);
	endtask

	task automatic test_nwrite_slot0();
		int e0;
		int ack0;
		int err0;
		e0   = errors;
		ack0 = ack_pulses;
		err0 = err_pulses;
		write_user(40);
		pulse_nwr_req(12'd319);
		expect_packet(8'd0, 34'd0, 8'd255, 32);
		expect_packet(8'd0, 34'd256, 8'd63, 8);
		expect_beat(db_beat(16'h0201), 1'b1, "integrity doorbell slot 0");
		send_resp(16'h0201, TARGET_RESP_ID);
		wait_idle();
		check_count(ack_pulses - ack0, 1, "ack pulses");
		check_count(err_pulses - err0, 0, "error pulses");
		check_count(cap_data.size(), 0, "stray ireq beats");
		report_test("nwrite_slot0", e0);
	endtask

	task automatic test_nwrite_slot1_timeout();
		int e0;
		int ack0;
		int err0;
		e0   = errors;
		ack0 = ack_pulses;
		err0 = err_pulses;
		write_user(4);
		pulse_nwr_req(12'd31);
		expect_packet(8'd1, TARGET_ADDR_STEP, 8'd31, 4);
		expect_beat(db_beat(16'h0200), 1'b1, "integrity doorbell slot 1");
		wait_idle();
		check_count(err_pulses - err0, 1, "integrity timeout pulses");
		check_err(seen_err_type, ERR_INTEG_TIMEOUT, "error type");
		check_id(seen_err_id, DES_ID, "error target id");
		check_count(ack_pulses - ack0, 0, "ack pulses");
		check_count(cap_data.size(), 0, "stray ireq beats");
		report_test("nwrite_slot1_timeout", e0);
	endtask

	initial begin
		log_rst            = 1'b1;
		self_check_i       = 1'b0;
		nwr_req_i          = 1'b0;
		nwr_size_i         = '0;
		link_initialized_i = 1'b1;
		user_tvalid_i      = 1'b0;
		user_tdata_i       = '0;
		user_tlast_i       = 1'b0;
		iresp_tvalid_i     = 1'b0;
		iresp_tdata_i      = '0;
		iresp_tuser_i      = '0;
		repeat (3) @(posedge log_clk);
		log_rst <= 1'b0;
		@(posedge log_clk);

		test_self_check_ready();
		test_self_check_busy();
		test_self_check_timeout();
		test_nwrite_slot0();
		test_nwrite_slot1_timeout();

		// bound protocol assertions count as errors too
		if (u_dut.u_asserts.fails != 0) begin
			errors += u_dut.u_asserts.fails;
			$display("protocol assertions failed %0d times", u_dut.u_asserts.fails);
		end

		$display("summary: 5 tests, %0d checks, %0d errors, %0d cycles", checks, errors, cycles);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
hw/srio_req_pkg.sv
hw/srio_req_if.sv
hw/user_data_fifo.sv
hw/req_sequencer.sv
hw/req_framer.sv
hw/db_requester.sv
tb/db_requester_asserts.sv
tb/db_requester_tb.sv

/* Makefile */
# Verilator build and run for the RapidIO requester testbench

VERILATOR ?= verilator
TOP       ?= db_requester_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Finished with errors
PASS_MSG  ?= Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
